/* rtl/aes_settings.svh */
`ifndef AES_SETTINGS_SVH
`define AES_SETTINGS_SVH

// AES-128 data widths
`define AES_BLOCK_BITS 128
`define AES_WORD_BITS 32
`define AES_BYTE_BITS 8

// schedule depth
`define AES_NUM_ROUNDS 10
`define AES_NUM_ROUND_KEYS 11 // initial key plus one per round

`endif

/* rtl/aesPkg.sv */
`default_nettype none

`include "aes_settings.svh"

package aesPkg;

        typedef logic [`AES_BLOCK_BITS-1:0] aesBlock; // state block or round key
        typedef logic [`AES_WORD_BITS-1:0] aesWord;
        typedef logic [`AES_BYTE_BITS-1:0] aesByte;
        typedef logic [3:0] roundIndex; // 0 to 10

        typedef enum logic {
                idle,
                rounds
        } engineState;

        //////////////////////////////
        // forward S-box
        // row n holds the outputs for inputs n0 to nf
        localparam logic [2047:0] sboxTable = {
                128'h63_7c_77_7b_f2_6b_6f_c5_30_01_67_2b_fe_d7_ab_76,
                128'hca_82_c9_7d_fa_59_47_f0_ad_d4_a2_af_9c_a4_72_c0,
                128'hb7_fd_93_26_36_3f_f7_cc_34_a5_e5_f1_71_d8_31_15,
                128'h04_c7_23_c3_18_96_05_9a_07_12_80_e2_eb_27_b2_75,
                128'h09_83_2c_1a_1b_6e_5a_a0_52_3b_d6_b3_29_e3_2f_84,
                128'h53_d1_00_ed_20_fc_b1_5b_6a_cb_be_39_4a_4c_58_cf,
                128'hd0_ef_aa_fb_43_4d_33_85_45_f9_02_7f_50_3c_9f_a8,
                128'h51_a3_40_8f_92_9d_38_f5_bc_b6_da_21_10_ff_f3_d2,
                128'hcd_0c_13_ec_5f_97_44_17_c4_a7_7e_3d_64_5d_19_73,
                128'h60_81_4f_dc_22_2a_90_88_46_ee_b8_14_de_5e_0b_db,
                128'he0_32_3a_0a_49_06_24_5c_c2_d3_ac_62_91_95_e4_79,
                128'he7_c8_37_6d_8d_d5_4e_a9_6c_56_f4_ea_65_7a_ae_08,
                128'hba_78_25_2e_1c_a6_b4_c6_e8_dd_74_1f_4b_bd_8b_8a,
                128'h70_3e_b5_66_48_03_f6_0e_61_35_57_b9_86_c1_1d_9e,
                128'he1_f8_98_11_69_d9_8e_94_9b_1e_87_e9_ce_55_28_df,
                128'h8c_a1_89_0d_bf_e6_42_68_41_99_2d_0f_b0_54_bb_16
        };

        // entry 0 sits in the top byte of the table
        function automatic aesByte sboxLookup(input aesByte value);
                return sboxTable[8 * (255 - int'(value)) +: 8];
        endfunction

        //////////////////////////////
        // Rcon byte for round key 1 to 10
        function automatic aesByte roundConstant(input roundIndex round);
                aesByte rcon;
                case (round)
                        4'd1:    rcon = 8'h01;
                        4'd2:    rcon = 8'h02;
                        4'd3:    rcon = 8'h04;
                        4'd4:    rcon = 8'h08;
                        4'd5:    rcon = 8'h10;
                        4'd6:    rcon = 8'h20;
                        4'd7:    rcon = 8'h40;
                        4'd8:    rcon = 8'h80;
                        4'd9:    rcon = 8'h1b; // reduced by the field polynomial
                        4'd10:   rcon = 8'h36;
                        default: rcon = 8'h00; // key 0 has no constant
                endcase
                return rcon;
        endfunction

endpackage

`default_nettype wire

/* rtl/roundFunction.sv */
`timescale 1ns/1ns
`default_nettype none

module roundFunction import aesPkg::*; (
        input  wire aesBlock stateIn,
        input  wire aesBlock roundKey,
        input  wire logic    finalRound,
        output aesBlock      stateOut
);

        // byte i is row i%4 of column i/4, byte 0 in the top bits
        aesByte subBytes [16];
        aesByte shiftBytes [16];
        aesByte mixBytes [16];
        aesByte colSum [4];

        // multiply by x in GF(2^8)
        function automatic aesByte xtime(input aesByte value);
                return {value[6:0], 1'b0} ^ (8'h1b & {8{value[7]}});
        endfunction

        //////////////////////////////
        always_comb begin
                for (int i = 0; i < 16; i++) begin
                        subBytes[i] = sboxLookup(stateIn[8*(15 - i) +: 8]);
                end

                // row r moves left by r columns
                for (int c = 0; c < 4; c++) begin
                        for (int r = 0; r < 4; r++) begin
                                shiftBytes[4*c + r] = subBytes[4*((c + r) % 4) + r];
                        end
                end

                for (int c = 0; c < 4; c++) begin
                        colSum[c] = shiftBytes[4*c] ^ shiftBytes[4*c + 1]
                                  ^ shiftBytes[4*c + 2] ^ shiftBytes[4*c + 3];
                        for (int r = 0; r < 4; r++) begin
                                mixBytes[4*c + r] = shiftBytes[4*c + r] ^ colSum[c]
                                        ^ xtime(shiftBytes[4*c + r] ^ shiftBytes[4*c + (r + 1) % 4]);
                        end
                end

                for (int i = 0; i < 16; i++) begin
                        if (finalRound) begin
                                stateOut[8*(15 - i) +: 8] = shiftBytes[i] ^ roundKey[8*(15 - i) +: 8];
                        end else begin
                                stateOut[8*(15 - i) +: 8] = mixBytes[i] ^ roundKey[8*(15 - i) +: 8];
                        end
                end
        end

endmodule

`default_nettype wire

/* rtl/keyExpander.sv */
`timescale 1ns/1ns
`default_nettype none

`include "aes_settings.svh"

module keyExpander import aesPkg::*; (
        input  wire logic      startTransition,
        input  wire logic      resetModule,
        input  wire logic      keyLoad,
        input  wire aesBlock   cipherKey,
        input  wire logic      busy,
        output logic           keyWrite,
        output roundIndex      keyWriteIndex,
        output aesBlock        keyWriteData
);

        aesBlock roundKey; // key written this cycle
        roundIndex roundCount;
        roundIndex nextCount;
        logic expanding;
        logic acceptKey;

        aesWord rotWord;
        aesWord subWord;
        aesWord tempWord;
        aesWord nextWords [4];

        // no new key while a block is in flight
        assign acceptKey = keyLoad && !busy;
        assign nextCount = roundCount + 4'd1;

        //////////////////////////////
        // next round key from the one held
        always_comb begin
                rotWord = {roundKey[23:0], roundKey[31:24]}; // rotate w3 left by a byte
                for (int b = 0; b < 4; b++) begin
                        subWord[8*b +: 8] = sboxLookup(rotWord[8*b +: 8]);
                end
                tempWord = subWord ^ {roundConstant(nextCount), 24'h000000};

                nextWords[0] = roundKey[127:96] ^ tempWord;
                nextWords[1] = roundKey[95:64] ^ nextWords[0];
                nextWords[2] = roundKey[63:32] ^ nextWords[1];
                nextWords[3] = roundKey[31:0] ^ nextWords[2];
        end

        always_ff @(posedge startTransition) begin
                if (resetModule) begin
                        expanding <= 1'b0;
                        roundCount <= '0;
                end else if (acceptKey) begin
                        expanding <= 1'b1; // also restarts a running expansion
                        roundCount <= '0;
                end else if (expanding) begin
                        if (roundCount == roundIndex'(`AES_NUM_ROUND_KEYS - 1)) begin
                                expanding <= 1'b0; // last entry written this edge
                        end else begin
                                roundCount <= nextCount;
                        end
                end
        end

        always_ff @(posedge startTransition) begin
                if (resetModule) begin
                        roundKey <= '0;
                end else if (acceptKey) begin
                        roundKey <= cipherKey;
                end else if (expanding) begin
                        roundKey <= {nextWords[0], nextWords[1], nextWords[2], nextWords[3]};
                end
        end

        // one store entry per cycle while expanding
        assign keyWrite = expanding;
        assign keyWriteIndex = roundCount;
        assign keyWriteData = roundKey;

endmodule

`default_nettype wire

/* rtl/roundKeyStore.sv */
`timescale 1ns/1ns
`default_nettype none

`include "aes_settings.svh"

module roundKeyStore import aesPkg::*; (
        input  wire logic      startTransition,
        input  wire logic      resetModule,
        input  wire logic      keyWrite,
        input  wire roundIndex keyWriteIndex,
        input  wire aesBlock   keyWriteData,
        input  wire roundIndex readIndex,
        output aesBlock        readKey,
        output logic           keyReady
);

        aesBlock keyStore [`AES_NUM_ROUND_KEYS];

        //////////////////////////////
        // write port
        always_ff @(posedge startTransition) begin
                if (keyWrite) begin
                        keyStore[keyWriteIndex] <= keyWriteData;
                end
        end

        // entry 0 opens a new schedule and the last entry completes it
        always_ff @(posedge startTransition) begin
                if (resetModule) begin
                        keyReady <= 1'b0;
                end else if (keyWrite) begin
                        if (keyWriteIndex == '0) begin
                                keyReady <= 1'b0;
                        end else if (keyWriteIndex == roundIndex'(`AES_NUM_ROUND_KEYS - 1)) begin
                                keyReady <= 1'b1;
                        end
                end
        end

        assign readKey = keyStore[readIndex]; // same-cycle read

endmodule

`default_nettype wire

/* rtl/blockCipherEngine.sv */
`timescale 1ns/1ns
`default_nettype none

`include "aes_settings.svh"

module blockCipherEngine import aesPkg::*; (
        input  wire logic    startTransition,
        input  wire logic    resetModule,
        input  wire logic    dataValid,
        input  wire aesBlock plainText,
        input  wire logic    keyReady,
        input  wire aesBlock readKey,
        output roundIndex    readIndex,
        output aesBlock      cipherText,
        output logic         cipherValid,
        output logic         busy
);

        engineState state;
        aesBlock stateBlock;
        aesBlock roundOut;
        roundIndex roundCount; // round applied at the next edge
        logic finalRound;
        logic startBlock;

        assign startBlock = (state == idle) && dataValid && keyReady;
        assign finalRound = (roundCount == roundIndex'(`AES_NUM_ROUNDS));

        // key 0 for the initial addition, then the key of the current round
        assign readIndex = (state == idle) ? roundIndex'(0) : roundCount;
        assign busy = (state == rounds);

        roundFunction u_roundFunction (
                .stateIn    (stateBlock),
                .roundKey   (readKey),
                .finalRound (finalRound),
                .stateOut   (roundOut)
        );

        //////////////////////////////
        // control
        always_ff @(posedge startTransition) begin
                if (resetModule) begin
                        state <= idle;
                        roundCount <= '0;
                        cipherValid <= 1'b0;
                        cipherText <= '0;
                end else begin
                        cipherValid <= 1'b0;
                        case (state)
                                idle: begin
                                        if (startBlock) begin
                                                state <= rounds;
                                                roundCount <= 4'd1;
                                        end
                                end
                                rounds: begin
                                        if (finalRound) begin
                                                state <= idle;
                                                roundCount <= '0;
                                                cipherValid <= 1'b1;
                                                cipherText <= roundOut; // held until the next result
                                        end else begin
                                                roundCount <= roundCount + 4'd1;
                                        end
                                end
                                default: state <= idle;
                        endcase
                end
        end

        //////////////////////////////
        // running state block
        always_ff @(posedge startTransition) begin
                if (startBlock) begin
                        stateBlock <= plainText ^ readKey; // initial AddRoundKey
                end else if (state == rounds) begin
                        stateBlock <= roundOut;
                end
        end

endmodule

`default_nettype wire

/* rtl/aesEncryptTop.sv */
`timescale 1ns/1ns
`default_nettype none

module aesEncryptTop import aesPkg::*; (
        input  wire logic    startTransition,
        input  wire logic    resetModule,
        input  wire logic    keyLoad,
        input  wire aesBlock cipherKey,
        input  wire logic    dataValid,
        input  wire aesBlock plainText,
        output wire aesBlock cipherText,
        output wire logic    cipherValid,
        output wire logic    busy,
        output wire logic    keyReady
);

        // expander to store
        logic keyWrite;
        roundIndex keyWriteIndex;
        aesBlock keyWriteData;

        // store to engine
        roundIndex readIndex;
        aesBlock readKey;

        //////////////////////////////
        keyExpander u_keyExpander (
                .startTransition (startTransition),
                .resetModule     (resetModule),
                .keyLoad         (keyLoad),
                .cipherKey       (cipherKey),
                .busy            (busy), // key changes wait for the block
                .keyWrite        (keyWrite),
                .keyWriteIndex   (keyWriteIndex),
                .keyWriteData    (keyWriteData)
        );

        roundKeyStore u_roundKeyStore (
                .startTransition (startTransition),
                .resetModule     (resetModule),
                .keyWrite        (keyWrite),
                .keyWriteIndex   (keyWriteIndex),
                .keyWriteData    (keyWriteData),
                .readIndex       (readIndex),
                .readKey         (readKey),
                .keyReady        (keyReady)
        );

        blockCipherEngine u_blockCipherEngine (
                .startTransition (startTransition),
                .resetModule     (resetModule),
                .dataValid       (dataValid),
                .plainText       (plainText),
                .keyReady        (keyReady),
                .readKey         (readKey),
                .readIndex       (readIndex),
                .cipherText      (cipherText),
                .cipherValid     (cipherValid),
                .busy            (busy)
        );

endmodule

`default_nettype wire

/* bench/aesVectors.svh */
`ifndef AES_VECTORS_SVH
`define AES_VECTORS_SVH

// FIPS-197 appendix C.1
localparam aesBlock fipsKey = 128'h000102030405060708090a0b0c0d0e0f;
localparam aesBlock fipsPlain = 128'h00112233445566778899aabbccddeeff;
localparam aesBlock fipsCipher = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

// FIPS-197 appendix B, cipher example
localparam aesBlock exampleKey = 128'h2b7e151628aed2a6abf7158809cf4f3c;
localparam aesBlock examplePlain = 128'h3243f6a8885a308d313198a2e0370734;
localparam aesBlock exampleCipher = 128'h3925841d02dc09fbdc118597196a0b32;

// all-zero key and block
localparam aesBlock zeroKey = 128'h0;
localparam aesBlock zeroPlain = 128'h0;
localparam aesBlock zeroCipher = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

// data pushed while a block is in flight, never encrypted
localparam aesBlock strayPlain = 128'hdeadbeef_0badf00d_12345678_9abcdef0;

`endif

/* bench/aesEncryptTb.sv */
`timescale 1ns/1ns
`default_nettype none

module aesEncryptTb import aesPkg::*; ();

        localparam int clockPeriod = 4;
        localparam int cycleBudget = 400;
        localparam int waitLimit = 40; // cycles before a wait gives up

        logic startTransition;
        logic resetModule;
        logic keyLoad;
        aesBlock cipherKey;
        logic dataValid;
        aesBlock plainText;
        aesBlock cipherText;
        logic cipherValid;
        logic busy;
        logic keyReady;

        int errorCount;
        int checkCount;

        `include "aesVectors.svh"

        aesEncryptTop u_aesEncryptTop (
                .startTransition (startTransition),
                .resetModule     (resetModule),
                .keyLoad         (keyLoad),
                .cipherKey       (cipherKey),
                .dataValid       (dataValid),
                .plainText       (plainText),
                .cipherText      (cipherText),
                .cipherValid     (cipherValid),
                .busy            (busy),
                .keyReady        (keyReady)
        );

        always #(clockPeriod / 2) startTransition = ~startTransition;

        //////////////////////////////
        // helpers
        task automatic nextCycle();
                @(posedge startTransition);
                #1; // drive and sample point
        endtask

        task automatic compareBlock(input string name, input aesBlock expected,
                                    input aesBlock actual);
                checkCount++;
                assert (actual === expected) else begin
                        errorCount++;
                        $display("ERROR at %0t ns: %s expected %h, actual %h",
                                 $time, name, expected, actual);
                end
        endtask

        task automatic compareFlag(input string name, input logic expected, input logic actual);
                checkCount++;
                assert (actual === expected) else begin
                        errorCount++;
                        $display("ERROR at %0t ns: %s expected %b, actual %b",
                                 $time, name, expected, actual);
                end
        endtask

        task automatic compareCount(input string name, input int expected, input int actual);
                checkCount++;
                assert (actual == expected) else begin
                        errorCount++;
                        $display("ERROR at %0t ns: %s expected %0d, actual %0d",
                                 $time, name, expected, actual);
                end
        endtask

        task automatic reportFailure(input string what);
                errorCount++;
                $display("at %0t ns: %s", $time, what);
        endtask

        // strobe a key and count cycles until the whole schedule is stored
        task automatic loadKey(input aesBlock key);
                int cycles;
                cipherKey = key;
                keyLoad = 1'b1;
                nextCycle(); // edge E
                keyLoad = 1'b0;
                nextCycle();
                cycles = 1;
                compareFlag("keyReady", 1'b0, keyReady); // entry 0 written
                while (!keyReady && cycles < waitLimit) begin
                        nextCycle();
                        cycles++;
                end
                assert (keyReady === 1'b1) else reportFailure("keyReady never rose after keyLoad");
                compareCount("key load latency", 11, cycles);
        endtask

        // returns in the cycle where cipherValid is high
        task automatic encryptBlock(input aesBlock plain, input aesBlock expected);
                int cycles;
                plainText = plain;
                dataValid = 1'b1;
                nextCycle(); // edge D
                dataValid = 1'b0;
                compareFlag("busy", 1'b1, busy);
                cycles = 0;
                while (!cipherValid && cycles < waitLimit) begin
                        nextCycle();
                        cycles++;
                end
                assert (cipherValid === 1'b1) else
                        reportFailure("cipherValid never rose after dataValid");
                compareCount("cipher latency", 10, cycles);
                compareBlock("cipherText", expected, cipherText);
                compareFlag("busy", 1'b0, busy);
        endtask

        //////////////////////////////
        // directed tests
        task automatic testKnownAnswer();
                loadKey(fipsKey);
                encryptBlock(fipsPlain, fipsCipher);
                nextCycle();
                compareFlag("cipherValid", 1'b0, cipherValid); // one-cycle strobe
                compareFlag("busy", 1'b0, busy);
                compareBlock("cipherText", fipsCipher, cipherText);
        endtask

        task automatic testKeyReload();
                compareFlag("keyReady", 1'b1, keyReady);
                loadKey(exampleKey);
                encryptBlock(examplePlain, exampleCipher);
                nextCycle();
        endtask

        task automatic testBackToBack();
                encryptBlock(examplePlain, exampleCipher);
                encryptBlock(examplePlain, exampleCipher); // started while cipherValid is high
                nextCycle();
                compareFlag("cipherValid", 1'b0, cipherValid);
        endtask

        task automatic testBusyProtection();
                int strobes;
                loadKey(zeroKey);
                plainText = zeroPlain;
                dataValid = 1'b1;
                nextCycle();
                strobes = 0;
                for (int cycle = 0; cycle < 20; cycle++) begin
                        // stray strobes land on edges D+3 and D+6
                        dataValid = (cycle == 2);
                        plainText = (cycle == 2) ? strayPlain : zeroPlain;
                        keyLoad = (cycle == 5);
                        cipherKey = fipsKey;
                        nextCycle();
                        if (cipherValid) begin
                                strobes++;
                                compareBlock("cipherText", zeroCipher, cipherText);
                        end
                        compareFlag("keyReady", 1'b1, keyReady);
                end
                compareCount("cipherValid strobes", 1, strobes);
        endtask

        task automatic testResetMidBlock();
                plainText = fipsPlain;
                dataValid = 1'b1;
                nextCycle();
                dataValid = 1'b0;
                repeat (4) nextCycle();
                compareFlag("busy", 1'b1, busy);
                resetModule = 1'b1;
                repeat (2) nextCycle();
                resetModule = 1'b0;
                for (int cycle = 0; cycle < 15; cycle++) begin
                        compareFlag("cipherValid", 1'b0, cipherValid);
                        compareFlag("busy", 1'b0, busy);
                        compareFlag("keyReady", 1'b0, keyReady);
                        compareBlock("cipherText", 128'h0, cipherText);
                        dataValid = (cycle == 3); // no schedule held, so dropped
                        nextCycle();
                end
                loadKey(fipsKey);
                encryptBlock(fipsPlain, fipsCipher);
                nextCycle();
        endtask

        //////////////////////////////
        initial begin
                errorCount = 0;
                checkCount = 0;
                startTransition = 1'b0;
                resetModule = 1'b1;
                keyLoad = 1'b0;
                cipherKey = '0;
                dataValid = 1'b0;
                plainText = '0;
                repeat (10) @(posedge startTransition);
                #1;
                resetModule = 1'b0;

                testKnownAnswer();
                testKeyReload();
                testBackToBack();
                testBusyProtection();
                testResetMidBlock();

                $display("checks: %0d, errors: %0d", checkCount, errorCount);
                if (errorCount == 0) begin
                        $display("RESULT: PASS");
                end else begin
                        $display("RESULT: FAIL");
                end
                $finish;
        end

        // twice the cycle budget of all tests
        initial begin
                #(2 * cycleBudget * clockPeriod);
                $display("watchdog expired, the tests did not finish in time");
                $display("checks: %0d, errors: %0d", checkCount, errorCount + 1);
                $display("RESULT: FAIL");
                $finish;
        end

endmodule

`default_nettype wire

/* src.f */
+incdir+rtl
+incdir+bench
rtl/aesPkg.sv
rtl/roundFunction.sv
rtl/keyExpander.sv
rtl/roundKeyStore.sv
rtl/blockCipherEngine.sv
rtl/aesEncryptTop.sv
bench/aesEncryptTb.sv

/* Bender.yml */
package:
  name: aes_encrypt

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/aesPkg.sv
      - rtl/roundFunction.sv
      - rtl/keyExpander.sv
      - rtl/roundKeyStore.sv
      - rtl/blockCipherEngine.sv
      - rtl/aesEncryptTop.sv
  - target: test
    include_dirs:
      - rtl
      - bench
    files:
      - bench/aesEncryptTb.sv
